// File: logic/cpuPkg.sv
package cpuPkg;

  // vector types with a meaning of their own
  typedef logic [15:0] wordT;
  typedef logic [15:0] instrT;
  typedef logic [2:0]  regIdxT;
  typedef logic [2:0]  regSelT;
  typedef logic [2:0]  opcodeT;
  typedef logic [1:0]  aluOpT;
  typedef logic [1:0]  shiftT;
  typedef logic [1:0]  wbSelT;

  // instruction field positions
  localparam int opcodeMsb = 15;
  localparam int opcodeLsb = 13;
  localparam int opMsb     = 12;
  localparam int opLsb     = 11;
  localparam int rnMsb     = 10;
  localparam int rnLsb     = 8;
  localparam int rdMsb     = 7;
  localparam int rdLsb     = 5;
  localparam int shiftMsb  = 4;
  localparam int shiftLsb  = 3;
  localparam int rmMsb     = 2;
  localparam int rmLsb     = 0;
  localparam int immMsb    = 7;

  // one-hot register field choice
  localparam regSelT selRm = 3'b001;
  localparam regSelT selRd = 3'b010;
  localparam regSelT selRn = 3'b100;

  // major opcodes
  localparam opcodeT opMove = 3'b110;
  localparam opcodeT opAlu  = 3'b101;

  // op field, ALU meaning
  localparam aluOpT aluAdd = 2'b00;
  localparam aluOpT aluSub = 2'b01;
  localparam aluOpT aluAnd = 2'b10;
  localparam aluOpT aluNot = 2'b11;
  // op field under opMove
  localparam aluOpT movReg = 2'b00;
  localparam aluOpT movImm = 2'b10;

  localparam shiftT shNone       = 2'b00;
  localparam shiftT shLeft       = 2'b01;
  localparam shiftT shRightLogic = 2'b10;
  localparam shiftT shRightArith = 2'b11;

  localparam wbSelT wbResult = 2'b01;
  localparam wbSelT wbImm    = 2'b10;

endpackage

// File: logic/regFile.sv
module regFile (
  input  logic          clk,
  input  logic          arstN,
  input  cpuPkg::wordT   writeData,
  input  cpuPkg::regIdxT regNum,
  input  logic          regWrite,
  output cpuPkg::wordT   readData
);

  logic [7:0]   regOneHot;
  logic [7:0]   loadEn;
  cpuPkg::wordT entry [8];

  // one register number serves both read and write
  assign regOneHot = 8'b1 << regNum;

  // write decoder gated by the write strobe
  assign loadEn = regOneHot & {8{regWrite}};

  // eight enabled entries
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      for (int i = 0; i < 8; i++) begin
        entry[i] <= '0;
      end
    end else begin
      for (int i = 0; i < 8; i++) begin
        if (loadEn[i]) begin
          entry[i] <= writeData;
        end
      end
    end
  end

  // and-or read mux on the same one-hot vector
  always_comb begin
    readData = '0;
    for (int i = 0; i < 8; i++) begin
      readData = readData | ({16{regOneHot[i]}} & entry[i]);
    end
  end

endmodule

// File: logic/instrDecoder.sv
module instrDecoder (
  input  logic           clk,
  input  logic           arstN,
  input  cpuPkg::instrT  instrIn,
  input  logic           loadInstr,
  input  cpuPkg::regSelT regSel,
  output cpuPkg::opcodeT opcode,
  output cpuPkg::aluOpT  op,
  output cpuPkg::shiftT  shift,
  output cpuPkg::regIdxT regNum,
  output cpuPkg::wordT   immExt
);

  cpuPkg::instrT  instrReg;
  cpuPkg::regIdxT rn;
  cpuPkg::regIdxT rd;
  cpuPkg::regIdxT rm;
  logic [7:0]     imm8;

  // instruction register, loaded on the strobe
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      instrReg <= '0;
    end else if (loadInstr) begin
      instrReg <= instrIn;
    end
  end

  // field split
  assign opcode = instrReg[cpuPkg::opcodeMsb:cpuPkg::opcodeLsb];
  assign op     = instrReg[cpuPkg::opMsb:cpuPkg::opLsb];
  assign rn     = instrReg[cpuPkg::rnMsb:cpuPkg::rnLsb];
  assign rd     = instrReg[cpuPkg::rdMsb:cpuPkg::rdLsb];
  assign shift  = instrReg[cpuPkg::shiftMsb:cpuPkg::shiftLsb];
  assign rm     = instrReg[cpuPkg::rmMsb:cpuPkg::rmLsb];
  assign imm8   = instrReg[cpuPkg::immMsb:0];

  // regSel is one-hot, so the fields never overlap
  assign regNum = ({3{regSel[0]}} & rm) |
                  ({3{regSel[1]}} & rd) |
                  ({3{regSel[2]}} & rn);

  assign immExt = {{8{imm8[7]}}, imm8};

endmodule

// File: logic/datapath.sv
module datapath (
  input  logic           clk,
  input  logic           arstN,
  input  cpuPkg::regIdxT regNum,
  input  cpuPkg::wordT   immExt,
  input  cpuPkg::aluOpT  op,
  input  cpuPkg::shiftT  shift,
  input  logic           regWrite,
  input  logic           loadA,
  input  logic           loadB,
  input  logic           loadC,
  input  logic           loadStatus,
  input  logic           aSelZero,
  input  cpuPkg::wbSelT  wbSel,
  output cpuPkg::wordT   datapathOut,
  output logic           zFlag,
  output logic           nFlag,
  output logic           vFlag
);

  cpuPkg::wordT readData;
  cpuPkg::wordT writeData;
  cpuPkg::wordT regA;
  cpuPkg::wordT regB;
  cpuPkg::wordT regC;
  cpuPkg::wordT bShifted;
  cpuPkg::wordT aIn;
  cpuPkg::wordT addB;
  cpuPkg::wordT sum;
  cpuPkg::wordT aluOut;
  logic         subtract;
  logic         arithOp;
  logic         addOverflow;
  logic [2:0]   status;

  regFile u_regFile (
    .clk       (clk),
    .arstN     (arstN),
    .writeData (writeData),
    .regNum    (regNum),
    .regWrite  (regWrite),
    .readData  (readData)
  );

  // operand registers hold whatever was read in the previous cycle
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      regA <= '0;
      regB <= '0;
    end else begin
      if (loadA) begin
        regA <= readData;
      end
      if (loadB) begin
        regB <= readData;
      end
    end
  end

  // shifter on B, one bit at most
  always_comb begin
    case (shift)
      cpuPkg::shLeft:       bShifted = {regB[14:0], 1'b0};
      cpuPkg::shRightLogic: bShifted = {1'b0, regB[15:1]};
      cpuPkg::shRightArith: bShifted = {regB[15], regB[15:1]};
      default:              bShifted = regB;
    endcase
  end

  // MOV and MVN run with A forced to zero
  assign aIn = aSelZero ? '0 : regA;

  // add and subtract share one adder, subtract as a + ~b + 1
  assign subtract    = (op == cpuPkg::aluSub);
  assign arithOp     = (op == cpuPkg::aluAdd) || subtract;
  assign addB        = subtract ? ~bShifted : bShifted;
  assign sum         = aIn + addB + {15'd0, subtract};
  assign addOverflow = (aIn[15] == addB[15]) && (sum[15] != aIn[15]);

  always_comb begin
    case (op)
      cpuPkg::aluAnd: aluOut = aIn & bShifted;
      cpuPkg::aluNot: aluOut = ~bShifted;
      default:        aluOut = sum;
    endcase
  end

  // result register C and status {z, n, v}
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      regC   <= '0;
      status <= '0;
    end else begin
      if (loadC) begin
        regC <= aluOut;
      end
      if (loadStatus) begin
        status <= {aluOut == '0, aluOut[15], addOverflow && arithOp};
      end
    end
  end

  assign datapathOut = regC;
  assign zFlag = status[2];
  assign nFlag = status[1];
  assign vFlag = status[0];

  // write-back source
  always_comb begin
    case (wbSel)
      cpuPkg::wbImm: writeData = immExt;
      default:       writeData = regC;
    endcase
  end

endmodule

// File: logic/controllerFsm.sv
module controllerFsm (
  input  logic           clk,
  input  logic           arstN,
  input  logic           start,
  input  cpuPkg::opcodeT opcode,
  input  cpuPkg::aluOpT  op,
  output logic           ready,
  output cpuPkg::regSelT regSel,
  output logic           regWrite,
  output logic           loadA,
  output logic           loadB,
  output logic           loadC,
  output logic           loadStatus,
  output logic           aSelZero,
  output cpuPkg::wbSelT  wbSel
);

  typedef enum logic [2:0] {
    sIdle,
    sDecode,
    sWriteImm,
    sGetA,
    sGetB,
    sCompute,
    sWriteReg
  } stateT;

  stateT state;
  stateT nextState;

  logic isMovImm;
  logic isMovReg;
  logic isAluOp;
  logic isCmp;
  logic isMvn;
  logic skipA;
  logic writesReg;

  // instruction kinds, tested here and nowhere else
  assign isMovImm  = (opcode == cpuPkg::opMove) && (op == cpuPkg::movImm);
  assign isMovReg  = (opcode == cpuPkg::opMove) && (op == cpuPkg::movReg);
  assign isAluOp   = (opcode == cpuPkg::opAlu);
  assign isCmp     = isAluOp && (op == cpuPkg::aluSub);
  assign isMvn     = isAluOp && (op == cpuPkg::aluNot);
  assign skipA     = isMovReg || isMvn;
  assign writesReg = isMovReg || (isAluOp && !isCmp);

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state <= sIdle;
    end else begin
      state <= nextState;
    end
  end

  always_comb begin
    nextState = state;
    case (state)
      sIdle: begin
        if (start) begin
          nextState = sDecode;
        end
      end
      sDecode: begin
        if (isMovImm) begin
          nextState = sWriteImm;
        end else if (skipA) begin
          nextState = sGetB;
        end else if (isAluOp) begin
          nextState = sGetA;
        end else begin
          // undefined encodings pass through a write stage that writes nothing
          nextState = sWriteReg;
        end
      end
      sGetA:     nextState = sGetB;
      sGetB:     nextState = sCompute;
      sCompute:  nextState = sWriteReg;
      sWriteReg: nextState = sIdle;
      sWriteImm: nextState = sIdle;
      default:   nextState = sIdle;
    endcase
  end

  always_comb begin
    regSel     = '0;
    regWrite   = 1'b0;
    loadA      = 1'b0;
    loadB      = 1'b0;
    loadC      = 1'b0;
    loadStatus = 1'b0;
    aSelZero   = 1'b0;
    wbSel      = cpuPkg::wbResult;
    case (state)
      sWriteImm: begin
        regSel   = cpuPkg::selRn;
        regWrite = 1'b1;
        wbSel    = cpuPkg::wbImm;
      end
      sGetA: begin
        regSel = cpuPkg::selRn;
        loadA  = 1'b1;
      end
      sGetB: begin
        regSel = cpuPkg::selRm;
        loadB  = 1'b1;
      end
      sCompute: begin
        loadC    = 1'b1;
        aSelZero = skipA;
      end
      sWriteReg: begin
        // CMP ends by loading the flags only, A and B still hold its operands
        regSel     = cpuPkg::selRd;
        regWrite   = writesReg;
        loadStatus = isCmp;
      end
      default: begin
      end
    endcase
  end

  assign ready = (state == sIdle);

endmodule

// File: logic/cpuTop.sv
module cpuTop (
  input  logic          clk,
  input  logic          arstN,
  input  cpuPkg::instrT instrIn,
  input  logic          loadInstr,
  input  logic          start,
  output cpuPkg::wordT  datapathOut,
  output logic          zFlag,
  output logic          nFlag,
  output logic          vFlag,
  output logic          ready
);

  cpuPkg::opcodeT opcode;
  cpuPkg::aluOpT  op;
  cpuPkg::shiftT  shift;
  cpuPkg::regIdxT regNum;
  cpuPkg::wordT   immExt;
  cpuPkg::regSelT regSel;
  cpuPkg::wbSelT  wbSel;
  logic           regWrite;
  logic           loadA;
  logic           loadB;
  logic           loadC;
  logic           loadStatus;
  logic           aSelZero;

  instrDecoder u_instrDecoder (
    .clk       (clk),
    .arstN     (arstN),
    .instrIn   (instrIn),
    .loadInstr (loadInstr),
    .regSel    (regSel),
    .opcode    (opcode),
    .op        (op),
    .shift     (shift),
    .regNum    (regNum),
    .immExt    (immExt)
  );

  controllerFsm u_controllerFsm (
    .clk        (clk),
    .arstN      (arstN),
    .start      (start),
    .opcode     (opcode),
    .op         (op),
    .ready      (ready),
    .regSel     (regSel),
    .regWrite   (regWrite),
    .loadA      (loadA),
    .loadB      (loadB),
    .loadC      (loadC),
    .loadStatus (loadStatus),
    .aSelZero   (aSelZero),
    .wbSel      (wbSel)
  );

  datapath u_datapath (
    .clk         (clk),
    .arstN       (arstN),
    .regNum      (regNum),
    .immExt      (immExt),
    .op          (op),
    .shift       (shift),
    .regWrite    (regWrite),
    .loadA       (loadA),
    .loadB       (loadB),
    .loadC       (loadC),
    .loadStatus  (loadStatus),
    .aSelZero    (aSelZero),
    .wbSel       (wbSel),
    .datapathOut (datapathOut),
    .zFlag       (zFlag),
    .nFlag       (nFlag),
    .vFlag       (vFlag)
  );

endmodule

// File: bench/cpuTop_checker.sv
module cpuTop_checker (
  input logic         clk,
  input logic         arstN,
  input logic         loadInstr,
  input logic         start,
  input logic         ready,
  input cpuPkg::wordT datapathOut,
  input logic         zFlag,
  input logic         nFlag,
  input logic         vFlag
);

  // core comes out of reset idle
  readyAfterReset: assert property (@(posedge clk) $rose(arstN) |-> ready)
    else $error("ready is low right after reset release");

  startClearsReady: assert property (@(posedge clk) disable iff (!arstN)
    (start && ready) |=> !ready)
    else $error("ready stayed high after an accepted start");

  // results settle on the edge that returns to idle, so the first idle cycle is skipped
  outputsHoldWhileReady: assert property (@(posedge clk) disable iff (!arstN)
    (ready && $past(ready)) |-> $stable({datapathOut, zFlag, nFlag, vFlag}))
    else $error("datapathOut or flags changed while ready");

  noLoadWhileBusy: assert property (@(posedge clk) disable iff (!arstN)
    !ready |-> !loadInstr)
    else $error("loadInstr raised while the core is busy");

endmodule

bind cpuTop cpuTop_checker u_cpuTop_checker (
  .clk         (clk),
  .arstN       (arstN),
  .loadInstr   (loadInstr),
  .start       (start),
  .ready       (ready),
  .datapathOut (datapathOut),
  .zFlag       (zFlag),
  .nFlag       (nFlag),
  .vFlag       (vFlag)
);

// File: bench/cpuTopTb.sv
module cpuTopTb;

  localparam int readyTimeout = 20;

  logic          clk;
  logic          arstN;
  cpuPkg::instrT instrIn;
  logic          loadInstr;
  logic          start;
  cpuPkg::wordT  datapathOut;
  logic          zFlag;
  logic          nFlag;
  logic          vFlag;
  logic          ready;

  // shadow state of the core
  cpuPkg::wordT modelRegs [8];
  cpuPkg::wordT modelC;
  logic         modelZ;
  logic         modelN;
  logic         modelV;
  logic [31:0]  lcgState;

  cpuTop u_cpuTop (
    .clk         (clk),
    .arstN       (arstN),
    .instrIn     (instrIn),
    .loadInstr   (loadInstr),
    .start       (start),
    .datapathOut (datapathOut),
    .zFlag       (zFlag),
    .nFlag       (nFlag),
    .vFlag       (vFlag),
    .ready       (ready)
  );

  always #50 clk = ~clk;

  function automatic logic [31:0] nextRandom();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  function automatic cpuPkg::instrT encodeMovImm(input cpuPkg::regIdxT rn,
                                                 input logic [7:0] imm8);
    return {cpuPkg::opMove, cpuPkg::movImm, rn, imm8};
  endfunction

  function automatic cpuPkg::instrT encodeOp(input cpuPkg::opcodeT opcode,
                                             input cpuPkg::aluOpT op,
                                             input cpuPkg::regIdxT rn,
                                             input cpuPkg::regIdxT rd,
                                             input cpuPkg::shiftT sh,
                                             input cpuPkg::regIdxT rm);
    return {opcode, op, rn, rd, sh, rm};
  endfunction

  function automatic cpuPkg::instrT encodeMovReg(input cpuPkg::regIdxT rd,
                                                 input cpuPkg::regIdxT rm,
                                                 input cpuPkg::shiftT sh);
    return encodeOp(cpuPkg::opMove, cpuPkg::movReg, 3'd0, rd, sh, rm);
  endfunction

  // one-bit shift of the B operand
  function automatic cpuPkg::wordT shiftValue(input cpuPkg::wordT v, input cpuPkg::shiftT sh);
    case (sh)
      cpuPkg::shLeft:       return v << 1;
      cpuPkg::shRightLogic: return v >> 1;
      cpuPkg::shRightArith: return $signed(v) >>> 1;
      default:              return v;
    endcase
  endfunction

  function automatic void applyModel(input cpuPkg::instrT instr);
    cpuPkg::opcodeT opc;
    cpuPkg::aluOpT  op;
    cpuPkg::wordT   a;
    cpuPkg::wordT   b;
    cpuPkg::wordT   diff;
    opc = instr[15:13];
    op  = instr[12:11];
    a   = modelRegs[instr[10:8]];
    b   = shiftValue(modelRegs[instr[2:0]], instr[4:3]);
    if (opc == cpuPkg::opMove && op == cpuPkg::movImm) begin
      modelRegs[instr[10:8]] = {{8{instr[7]}}, instr[7:0]};
    end else if (opc == cpuPkg::opMove && op == cpuPkg::movReg) begin
      modelC = b;
      modelRegs[instr[7:5]] = b;
    end else if (opc == cpuPkg::opAlu) begin
      case (op)
        cpuPkg::aluAdd: modelC = a + b;
        cpuPkg::aluAnd: modelC = a & b;
        cpuPkg::aluNot: modelC = ~b;
        default: begin
          diff   = a - b;
          modelC = diff;
          modelZ = (diff == 16'h0000);
          modelN = diff[15];
          modelV = (a[15] != b[15]) && (diff[15] != a[15]);
        end
      endcase
      if (op != cpuPkg::aluSub) begin
        modelRegs[instr[7:5]] = modelC;
      end
    end
  endfunction

  task automatic checkValue(input string name, input logic [15:0] actual,
                            input logic [15:0] expected);
    if (actual !== expected) begin
      $display("ERROR time %0t: %s is %h, expected %h", $time, name, actual, expected);
      $display("Simulation failed");
      $fatal(1, "value mismatch on %s", name);
    end
  endtask

  task automatic expectFlags(input logic z, input logic n, input logic v);
    checkValue("zFlag", {15'd0, zFlag}, {15'd0, z});
    checkValue("nFlag", {15'd0, nFlag}, {15'd0, n});
    checkValue("vFlag", {15'd0, vFlag}, {15'd0, v});
  endtask

  // polls ready at falling edges, away from the DUT's updates
  task automatic waitReadyLevel(input logic level);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (ready !== level && cycles < readyTimeout) begin
      @(negedge clk);
      cycles++;
    end
    if (ready !== level) begin
      $display("timeout while waiting for ready to become %0b", level);
      $display("Simulation failed");
      $fatal(1, "ready timeout");
    end
  endtask

  task automatic runInstr(input cpuPkg::instrT instr);
    @(posedge clk);
    instrIn   <= instr;
    loadInstr <= 1'b1;
    @(posedge clk);
    loadInstr <= 1'b0;
    start     <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    waitReadyLevel(1'b0);
    waitReadyLevel(1'b1);
  endtask

  task automatic execute(input cpuPkg::instrT instr);
    runInstr(instr);
    applyModel(instr);
    checkValue("datapathOut", datapathOut, modelC);
    expectFlags(modelZ, modelN, modelV);
  endtask

  task automatic readBack(input cpuPkg::regIdxT idx, input cpuPkg::wordT expected);
    execute(encodeMovReg(idx, idx, cpuPkg::shNone));
    checkValue($sformatf("datapathOut (r%0d)", idx), datapathOut, expected);
  endtask

  task automatic testReset();
    checkValue("ready", {15'd0, ready}, 16'h0001);
    checkValue("datapathOut", datapathOut, 16'h0000);
    expectFlags(1'b0, 1'b0, 1'b0);
  endtask

  task automatic testMovImm();
    execute(encodeMovImm(3'd0, 8'h05));
    execute(encodeMovImm(3'd1, 8'hfd));
    execute(encodeMovImm(3'd7, 8'h7f));
    execute(encodeMovImm(3'd2, 8'h80));
    readBack(3'd0, 16'h0005);
    readBack(3'd1, 16'hfffd);
    readBack(3'd7, 16'h007f);
    readBack(3'd2, 16'hff80);
  endtask

  task automatic testShifts();
    execute(encodeMovImm(3'd3, 8'h81));
    execute(encodeMovReg(3'd4, 3'd3, cpuPkg::shNone));
    checkValue("datapathOut", datapathOut, 16'hff81);
    execute(encodeMovReg(3'd4, 3'd3, cpuPkg::shLeft));
    checkValue("datapathOut", datapathOut, 16'hff02);
    execute(encodeMovReg(3'd4, 3'd3, cpuPkg::shRightLogic));
    checkValue("datapathOut", datapathOut, 16'h7fc0);
    execute(encodeMovReg(3'd4, 3'd3, cpuPkg::shRightArith));
    checkValue("datapathOut", datapathOut, 16'hffc0);
  endtask

  task automatic testAluOps();
    // equal compare sets zFlag so that a stray flag load below shows up
    execute(encodeOp(cpuPkg::opAlu, cpuPkg::aluSub, 3'd0, 3'd0, cpuPkg::shNone, 3'd0));
    expectFlags(1'b1, 1'b0, 1'b0);
    execute(encodeMovImm(3'd5, 8'h3c));
    execute(encodeMovImm(3'd6, 8'h0f));
    execute(encodeOp(cpuPkg::opAlu, cpuPkg::aluAdd, 3'd5, 3'd7, cpuPkg::shNone, 3'd6));
    checkValue("datapathOut", datapathOut, 16'h004b);
    // destination is also the first operand
    execute(encodeOp(cpuPkg::opAlu, cpuPkg::aluAnd, 3'd5, 3'd5, cpuPkg::shLeft, 3'd6));
    checkValue("datapathOut", datapathOut, 16'h001c);
    execute(encodeOp(cpuPkg::opAlu, cpuPkg::aluNot, 3'd0, 3'd6, cpuPkg::shNone, 3'd6));
    checkValue("datapathOut", datapathOut, 16'hfff0);
    execute(encodeOp(cpuPkg::opAlu, cpuPkg::aluAdd, 3'd7, 3'd7, cpuPkg::shLeft, 3'd7));
    checkValue("datapathOut", datapathOut, 16'h00e1);
    expectFlags(1'b1, 1'b0, 1'b0);
    readBack(3'd5, 16'h001c);
    readBack(3'd6, 16'hfff0);
  endtask

  task automatic testCompare();
    execute(encodeMovImm(3'd0, 8'h12));
    execute(encodeMovImm(3'd1, 8'h12));
    execute(encodeOp(cpuPkg::opAlu, cpuPkg::aluSub, 3'd0, 3'd7, cpuPkg::shNone, 3'd1));
    checkValue("datapathOut", datapathOut, 16'h0000);
    expectFlags(1'b1, 1'b0, 1'b0);
    execute(encodeMovImm(3'd2, 8'h05));
    execute(encodeMovImm(3'd3, 8'h09));
    execute(encodeOp(cpuPkg::opAlu, cpuPkg::aluSub, 3'd2, 3'd7, cpuPkg::shNone, 3'd3));
    checkValue("datapathOut", datapathOut, 16'hfffc);
    expectFlags(1'b0, 1'b1, 1'b0);
    // 0x7fc0 minus 0xff80 overflows into the sign bit
    execute(encodeMovImm(3'd4, 8'h80));
    execute(encodeMovReg(3'd4, 3'd4, cpuPkg::shRightLogic));
    execute(encodeMovImm(3'd5, 8'h80));
    execute(encodeOp(cpuPkg::opAlu, cpuPkg::aluSub, 3'd4, 3'd7, cpuPkg::shNone, 3'd5));
    checkValue("datapathOut", datapathOut, 16'h8040);
    expectFlags(1'b0, 1'b1, 1'b1);
    // rd of CMP is left alone
    readBack(3'd7, 16'h00e1);
  endtask

  task automatic testRandom();
    logic [31:0]   r;
    cpuPkg::instrT instr;
    for (int i = 0; i < 40; i++) begin
      r     = nextRandom();
      instr = r[23:8];
      if (r[31:30] == 2'b00) begin
        instr[15:13] = cpuPkg::opMove;
      end else if (r[31:30] != 2'b11) begin
        instr[15:13] = cpuPkg::opAlu;
      end
      execute(instr);
    end
    for (int k = 0; k < 8; k++) begin
      readBack(k[2:0], modelRegs[k]);
    end
  endtask

  initial begin
    clk       = 1'b0;
    arstN     = 1'b0;
    instrIn   = '0;
    loadInstr = 1'b0;
    start     = 1'b0;
    lcgState  = 32'h29e3;
    modelC    = '0;
    modelZ    = 1'b0;
    modelN    = 1'b0;
    modelV    = 1'b0;
    for (int i = 0; i < 8; i++) begin
      modelRegs[i] = '0;
    end
    repeat (3) @(posedge clk);
    arstN <= 1'b1;
    @(negedge clk);
    testReset();
    testMovImm();
    testShifts();
    testAluOps();
    testCompare();
    testRandom();
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

// File: cpuTop.f
logic/cpuPkg.sv
logic/regFile.sv
logic/instrDecoder.sv
logic/datapath.sv
logic/controllerFsm.sv
logic/cpuTop.sv
bench/cpuTop_checker.sv
bench/cpuTopTb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = cpuTopTb
FILELIST  = cpuTop.f
PASS_MSG  = Simulation completed successfully

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir
